// File: src/sb_consts.svh
// -----------------------------
// scoreboard size constants
// entry count, id width, commit ports,
// register file and data word sizes
// -----------------------------

`ifndef SB_CONSTS_SVH
`define SB_CONSTS_SVH

// entries in the circular store, must stay a power of two
`define SB_NR_ENTRIES 8

// transaction id width, log2 of the entry count
`define SB_ID_BITS 3

// commit ports offered to the commit stage
`define SB_NR_COMMIT 2

// general purpose register address width
`define SB_REG_BITS 5

// number of general purpose registers
`define SB_NR_REGS 32

// integer data width
`define SB_XLEN 32

`endif

// File: src/sb_pkg.sv
// -----------------------------
// scoreboard types
// functional units, entry, slot and
// write-back records
// -----------------------------

`include "sb_consts.svh"

package sb_pkg;

  // functional unit that will produce the result
  // NONE completes without a write-back
  typedef enum logic [2:0] {
    NONE,
    ALU,
    LOAD,
    STORE,
    MULT,
    CSR
  } fu_t;

  typedef logic [`SB_REG_BITS-1:0] reg_addr_t;
  typedef logic [`SB_ID_BITS-1:0]  trans_id_t;
  typedef logic [`SB_XLEN-1:0]     xlen_t;

  // one decoded instruction as seen by issue and commit
  typedef struct packed {
    logic      valid;
    fu_t       fu;
    reg_addr_t rd;
    trans_id_t trans_id;
    xlen_t     result;
  } sb_entry_t;

  // store slot, issued marks an occupied entry
  typedef struct packed {
    logic      issued;
    sb_entry_t sbe;
  } sb_slot_t;

  // single write-back port from the functional units
  typedef struct packed {
    logic      valid;
    trans_id_t trans_id;
    xlen_t     data;
  } wb_t;

endpackage

// File: src/sb_prio_select.sv
// -----------------------------
// fixed priority selector
// returns the payload of the lowest
// index request, any payload type
// -----------------------------

`include "sb_consts.svh"

module sb_prio_select #(
  parameter type payload_t = logic
) (
  // one request per entry plus one extra slot
  input  logic     [`SB_NR_ENTRIES:0] req_i,
  input  payload_t [`SB_NR_ENTRIES:0] data_i,
  output logic                        valid_o,
  output payload_t                    data_o
);

  // any request present
  assign valid_o = |req_i;

  // walk from the top down so the lowest index overwrites last
  always_comb begin : select
    data_o = payload_t'('0);
    for (int i = `SB_NR_ENTRIES; i >= 0; i--) begin
      if (req_i[i]) begin
        data_o = data_i[i];
      end
    end
  end

endmodule

// File: src/sb_entry_store.sv
// -----------------------------
// scoreboard entry store
// circular slot array with issue and
// commit pointers, write-back, flush
// -----------------------------

`include "sb_consts.svh"

module sb_entry_store (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic                                      flush_i,
  input  logic                                      flush_unissued_i,
  input  logic                                      unresolved_branch_i,
  // decode side
  input  sb_pkg::sb_entry_t                         decoded_instr_i,
  input  logic                                      decoded_instr_valid_i,
  input  logic                                      issue_ack_i,
  // issue side
  output sb_pkg::sb_entry_t                         issue_instr_o,
  output logic                                      issue_instr_valid_o,
  output logic                                      decoded_instr_ack_o,
  output logic                                      sb_full_o,
  // write-back
  input  sb_pkg::wb_t                               wb_i,
  // commit
  output sb_pkg::sb_entry_t [`SB_NR_COMMIT-1:0]     commit_instr_o,
  input  logic              [`SB_NR_COMMIT-1:0]     commit_ack_i,
  // slot view for clobber and forwarding
  output sb_pkg::sb_slot_t  [`SB_NR_ENTRIES-1:0]    slots_o
);

  // occupancy flags, reset with the control state
  logic [`SB_NR_ENTRIES-1:0] issued_q, issued_d;
  logic [`SB_NR_ENTRIES-1:0] valid_q, valid_d;
  // instruction payload
  sb_pkg::sb_entry_t [`SB_NR_ENTRIES-1:0] entry_q, entry_d;

  sb_pkg::trans_id_t issue_ptr_q, issue_ptr_d;
  sb_pkg::trans_id_t commit_ptr_q, commit_ptr_d;
  sb_pkg::trans_id_t fill_cnt_q, fill_cnt_d;
  sb_pkg::trans_id_t [`SB_NR_COMMIT-1:0] commit_idx;

  logic                            issue_en;
  logic [$clog2(`SB_NR_COMMIT):0]  num_commit;

  // all ones means seven entries in flight
  assign sb_full_o = &fill_cnt_q;

  // ------------------------------
  // issue interface
  // ------------------------------
  always_comb begin : issue_if
    issue_instr_o          = decoded_instr_i;
    // the entry index is the transaction id
    issue_instr_o.trans_id = issue_ptr_q;
    issue_instr_valid_o    = decoded_instr_valid_i & ~unresolved_branch_i & ~sb_full_o;
    decoded_instr_ack_o    = issue_ack_i & ~sb_full_o;
  end

  // slot view, valid and trans_id come from the control flags and index
  always_comb begin : slot_view
    for (int i = 0; i < `SB_NR_ENTRIES; i++) begin
      slots_o[i].issued       = issued_q[i];
      slots_o[i].sbe          = entry_q[i];
      slots_o[i].sbe.valid    = valid_q[i];
      slots_o[i].sbe.trans_id = sb_pkg::trans_id_t'(i);
    end
  end

  // commit port k looks k entries past the commit pointer
  for (genvar k = 0; k < `SB_NR_COMMIT; k++) begin : gen_commit
    assign commit_idx[k]     = commit_ptr_q + sb_pkg::trans_id_t'(k);
    assign commit_instr_o[k] = slots_o[commit_idx[k]].sbe;
  end

  // acks are contiguous from port 0 so a count is enough
  always_comb begin : commit_count
    num_commit = '0;
    for (int k = 0; k < `SB_NR_COMMIT; k++) begin
      if (commit_ack_i[k]) begin
        num_commit = num_commit + 1'b1;
      end
    end
  end

  // ------------------------------
  // next slot state
  // ------------------------------
  always_comb begin : next_state
    issued_d = issued_q;
    valid_d  = valid_q;
    entry_d  = entry_q;
    issue_en = 1'b0;

    // capture on handshake unless the un-issued part is flushed
    if (decoded_instr_valid_i && decoded_instr_ack_o && !flush_unissued_i) begin
      issue_en              = 1'b1;
      issued_d[issue_ptr_q] = 1'b1;
      valid_d[issue_ptr_q]  = decoded_instr_i.valid;
      entry_d[issue_ptr_q]  = issue_instr_o;
    end

    // write-back, dropped for entries that are not in flight
    if (wb_i.valid && issued_q[wb_i.trans_id]) begin
      valid_d[wb_i.trans_id]        = 1'b1;
      entry_d[wb_i.trans_id].result = wb_i.data;
    end

    // no unit to wait for, done one cycle after issue
    for (int i = 0; i < `SB_NR_ENTRIES; i++) begin
      if (issued_q[i] && entry_q[i].fu == sb_pkg::NONE) begin
        valid_d[i] = 1'b1;
      end
    end

    // retire acked entries
    for (int k = 0; k < `SB_NR_COMMIT; k++) begin
      if (commit_ack_i[k]) begin
        issued_d[commit_idx[k]] = 1'b0;
        valid_d[commit_idx[k]]  = 1'b0;
      end
    end

    // full flush overrides everything above
    if (flush_i) begin
      issued_d = '0;
      valid_d  = '0;
    end
  end

  // pointer and count updates
  always_comb begin : next_ptr
    issue_ptr_d  = issue_ptr_q + sb_pkg::trans_id_t'(issue_en);
    commit_ptr_d = commit_ptr_q + sb_pkg::trans_id_t'(num_commit);
    fill_cnt_d   = fill_cnt_q + sb_pkg::trans_id_t'(issue_en)
                   - sb_pkg::trans_id_t'(num_commit);
    if (flush_i) begin
      issue_ptr_d  = '0;
      commit_ptr_d = '0;
      fill_cnt_d   = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : ctrl_regs
    if (!rst_ni) begin
      issued_q     <= '0;
      valid_q      <= '0;
      issue_ptr_q  <= '0;
      commit_ptr_q <= '0;
      fill_cnt_q   <= '0;
    end else begin
      issued_q     <= issued_d;
      valid_q      <= valid_d;
      issue_ptr_q  <= issue_ptr_d;
      commit_ptr_q <= commit_ptr_d;
      fill_cnt_q   <= fill_cnt_d;
    end
  end

  always_ff @(posedge clk_i) begin : payload_regs
    entry_q <= entry_d;
  end

  // commit stage only acks finished work
  for (genvar k = 0; k < `SB_NR_COMMIT; k++) begin : gen_commit_chk
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      commit_ack_i[k] |-> commit_instr_o[k].valid)
      else $error("commit ack on port %0d without a valid entry", k);
  end

  // issue stage only acks an offered instruction
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_ack_i |-> issue_instr_valid_o)
    else $error("issue ack while issue valid is low");

endmodule

// File: src/sb_clobber.sv
// -----------------------------
// register clobber list
// per register, fu of the pending
// writer with the lowest entry index
// -----------------------------

`include "sb_consts.svh"

module sb_clobber (
  input  sb_pkg::sb_slot_t [`SB_NR_ENTRIES-1:0] slots_i,
  output sb_pkg::fu_t      [`SB_NR_REGS-1:0]    rd_clobber_o
);

  // candidate units, the extra top slot stays idle
  sb_pkg::fu_t [`SB_NR_ENTRIES:0] clobber_fu;

  always_comb begin : fu_list
    for (int i = 0; i < `SB_NR_ENTRIES; i++) begin
      clobber_fu[i] = slots_i[i].sbe.fu;
    end
    clobber_fu[`SB_NR_ENTRIES] = sb_pkg::NONE;
  end

  // ------------------------------
  // one selector per register
  // ------------------------------
  for (genvar r = 0; r < `SB_NR_REGS; r++) begin : gen_reg
    logic [`SB_NR_ENTRIES:0] clobber_req;

    // x0 never gets a writer
    always_comb begin : build_req
      clobber_req = '0;
      if (r != 0) begin
        for (int i = 0; i < `SB_NR_ENTRIES; i++) begin
          clobber_req[i] = slots_i[i].issued &&
                           (slots_i[i].sbe.rd == sb_pkg::reg_addr_t'(r));
        end
      end
    end

    // selector valid unused, NONE is the default payload
    sb_prio_select #(
      .payload_t(sb_pkg::fu_t)
    ) i_sel_clobber (
      .req_i   (clobber_req),
      .data_i  (clobber_fu),
      .valid_o (),
      .data_o  (rd_clobber_o[r])
    );
  end

  // x0 must read free whatever the selector returns
  always_comb begin : x0_chk
    assert final (rd_clobber_o[0] == sb_pkg::NONE)
      else $error("register 0 reported as clobbered");
  end

endmodule

// File: src/sb_operand_fwd.sv
// -----------------------------
// operand forwarding
// rs1 and rs2 from the write-back
// port or finished entries
// -----------------------------

`include "sb_consts.svh"

module sb_operand_fwd (
  input  sb_pkg::sb_slot_t [`SB_NR_ENTRIES-1:0] slots_i,
  input  sb_pkg::wb_t                           wb_i,
  input  sb_pkg::reg_addr_t                     rs1_i,
  input  sb_pkg::reg_addr_t                     rs2_i,
  output sb_pkg::xlen_t                         rs1_o,
  output logic                                  rs1_valid_o,
  output sb_pkg::xlen_t                         rs2_o,
  output logic                                  rs2_valid_o
);

  // source 0 is rs1, source 1 is rs2
  sb_pkg::reg_addr_t [1:0] rs_addr;
  logic              [1:0] sel_valid;
  sb_pkg::xlen_t     [1:0] sel_data;

  // write-back data first, then stored results by entry
  sb_pkg::xlen_t [`SB_NR_ENTRIES:0] fwd_data;

  // destination of the entry being written back
  sb_pkg::reg_addr_t wb_rd;
  logic              wb_live;

  assign rs_addr[0] = rs1_i;
  assign rs_addr[1] = rs2_i;

  assign wb_rd   = slots_i[wb_i.trans_id].sbe.rd;
  // only in-flight targets count, stale write-backs are dropped by the store
  assign wb_live = wb_i.valid & slots_i[wb_i.trans_id].issued;

  always_comb begin : data_list
    fwd_data[0] = wb_i.data;
    for (int i = 0; i < `SB_NR_ENTRIES; i++) begin
      fwd_data[i+1] = slots_i[i].sbe.result;
    end
  end

  // ------------------------------
  // one selector per source
  // ------------------------------
  for (genvar j = 0; j < 2; j++) begin : gen_src
    logic [`SB_NR_ENTRIES:0] fwd_req;

    always_comb begin : build_req
      fwd_req[0] = wb_live && (wb_rd == rs_addr[j]);
      for (int i = 0; i < `SB_NR_ENTRIES; i++) begin
        // finished and still in flight
        fwd_req[i+1] = slots_i[i].issued && slots_i[i].sbe.valid &&
                       (slots_i[i].sbe.rd == rs_addr[j]);
      end
    end

    sb_prio_select #(
      .payload_t(sb_pkg::xlen_t)
    ) i_sel_rs (
      .req_i   (fwd_req),
      .data_i  (fwd_data),
      .valid_o (sel_valid[j]),
      .data_o  (sel_data[j])
    );
  end

  assign rs1_o = sel_data[0];
  assign rs2_o = sel_data[1];

  // x0 is read from the register file, never forwarded
  assign rs1_valid_o = sel_valid[0] & (|rs1_i);
  assign rs2_valid_o = sel_valid[1] & (|rs2_i);

endmodule

// File: src/scoreboard_top.sv
// -----------------------------
// issue scoreboard top
// entry store, clobber list and
// operand forwarding
// -----------------------------

`include "sb_consts.svh"

module scoreboard_top (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  // decode side
  input  sb_pkg::sb_entry_t                     decoded_instr_i,
  input  logic                                  decoded_instr_valid_i,
  output logic                                  decoded_instr_ack_o,
  // issue side
  output sb_pkg::sb_entry_t                     issue_instr_o,
  output logic                                  issue_instr_valid_o,
  input  logic                                  issue_ack_i,
  // control
  input  logic                                  unresolved_branch_i,
  input  logic                                  flush_i,
  input  logic                                  flush_unissued_i,
  // write-back
  input  sb_pkg::wb_t                           wb_i,
  // commit
  output sb_pkg::sb_entry_t [`SB_NR_COMMIT-1:0] commit_instr_o,
  input  logic              [`SB_NR_COMMIT-1:0] commit_ack_i,
  // operand read
  input  sb_pkg::reg_addr_t                     rs1_i,
  input  sb_pkg::reg_addr_t                     rs2_i,
  output sb_pkg::xlen_t                         rs1_o,
  output logic                                  rs1_valid_o,
  output sb_pkg::xlen_t                         rs2_o,
  output logic                                  rs2_valid_o,
  // status
  output sb_pkg::fu_t       [`SB_NR_REGS-1:0]   rd_clobber_o,
  output logic                                  sb_full_o
);

  // slot array shared by all three blocks
  sb_pkg::sb_slot_t [`SB_NR_ENTRIES-1:0] slots;

  sb_entry_store i_entry_store (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .flush_i               (flush_i),
    .flush_unissued_i      (flush_unissued_i),
    .unresolved_branch_i   (unresolved_branch_i),
    .decoded_instr_i       (decoded_instr_i),
    .decoded_instr_valid_i (decoded_instr_valid_i),
    .issue_ack_i           (issue_ack_i),
    .issue_instr_o         (issue_instr_o),
    .issue_instr_valid_o   (issue_instr_valid_o),
    .decoded_instr_ack_o   (decoded_instr_ack_o),
    .sb_full_o             (sb_full_o),
    .wb_i                  (wb_i),
    .commit_instr_o        (commit_instr_o),
    .commit_ack_i          (commit_ack_i),
    .slots_o               (slots)
  );

  sb_clobber i_clobber (
    .slots_i      (slots),
    .rd_clobber_o (rd_clobber_o)
  );

  sb_operand_fwd i_operand_fwd (
    .slots_i     (slots),
    .wb_i        (wb_i),
    .rs1_i       (rs1_i),
    .rs2_i       (rs2_i),
    .rs1_o       (rs1_o),
    .rs1_valid_o (rs1_valid_o),
    .rs2_o       (rs2_o),
    .rs2_valid_o (rs2_valid_o)
  );

endmodule

// File: dv/tb_scoreboard.sv
// ------------------------------
// scoreboard testbench
// table of issue, write-back, commit
// and flush steps with output checks
// ------------------------------

`include "sb_consts.svh"

module tb_scoreboard;
  timeunit 1ns;
  timeprecision 1ps;

  // one step of inputs, ctl is {issue ack, branch, flush, flush un-issued}
  typedef struct packed {
    logic              dec_valid;
    sb_pkg::fu_t       fu;
    sb_pkg::reg_addr_t rd;
    logic [3:0]        ctl;
    sb_pkg::wb_t       wb;
    logic [1:0]        ack;
    sb_pkg::reg_addr_t rs;
  } stim_t;

  // flags is {issue valid, decode ack, full, commit port 0 valid}
  typedef struct packed {
    logic [3:0]        flags;
    sb_pkg::trans_id_t tid;
    sb_pkg::xlen_t     cres;
    sb_pkg::reg_addr_t clob_reg;
    sb_pkg::fu_t       clob;
    logic              rsv;
    sb_pkg::xlen_t     rs;
  } exp_t;

  localparam sb_pkg::wb_t no_wb = '0;

  logic clk_i, rst_ni, decoded_instr_valid_i, decoded_instr_ack_o, issue_instr_valid_o;
  logic issue_ack_i, unresolved_branch_i, flush_i, flush_unissued_i, sb_full_o;
  logic rs1_valid_o, rs2_valid_o;
  sb_pkg::sb_entry_t decoded_instr_i, issue_instr_o;
  sb_pkg::wb_t       wb_i;
  sb_pkg::sb_entry_t [`SB_NR_COMMIT-1:0] commit_instr_o;
  logic              [`SB_NR_COMMIT-1:0] commit_ack_i;
  sb_pkg::reg_addr_t rs1_i, rs2_i;
  sb_pkg::xlen_t     rs1_o, rs2_o;
  sb_pkg::fu_t       [`SB_NR_REGS-1:0] rd_clobber_o;

  stim_t stims[$];
  exp_t  exps[$];
  string names[$];
  int    n_rows = 0;
  int    errors = 0;
  // reference state for the random write-back steps
  logic          [`SB_NR_ENTRIES-1:0] mdl_valid;
  sb_pkg::xlen_t [`SB_NR_ENTRIES-1:0] mdl_res;

  scoreboard_top i_scoreboard_top (.*);

  function automatic sb_pkg::wb_t make_wb(sb_pkg::trans_id_t id, sb_pkg::xlen_t d);
    return '{1'b1, id, d};
  endfunction

  // in the random phase entries 4..7 write x7, entries 0 and 1 write x12
  function automatic sb_pkg::reg_addr_t model_rd(sb_pkg::trans_id_t id);
    return (id >= 3'd4) ? 5'd7 : 5'd12;
  endfunction

  // write-back hit first, then lowest finished entry
  function automatic logic [32:0] fwd_ref(sb_pkg::trans_id_t id, sb_pkg::xlen_t d,
                                          sb_pkg::reg_addr_t rs);
    if (model_rd(id) == rs) begin
      return {1'b1, d};
    end
    for (int i = 0; i < `SB_NR_ENTRIES; i++) begin
      if (mdl_valid[i] && model_rd(sb_pkg::trans_id_t'(i)) == rs) begin
        return {1'b1, mdl_res[i]};
      end
    end
    return {1'b0, 32'h0};
  endfunction

  task automatic add_row(string nm, stim_t s, exp_t e);
    names.push_back(nm);
    stims.push_back(s);
    exps.push_back(e);
  endtask

  task automatic drive_inputs(stim_t s);
    decoded_instr_valid_i = s.dec_valid;
    decoded_instr_i       = '{1'b0, s.fu, s.rd, 3'd0, 32'h0};
    {issue_ack_i, unresolved_branch_i, flush_i, flush_unissued_i} = s.ctl;
    wb_i         = s.wb;
    commit_ack_i = s.ack;
    // both source ports read the same register
    rs1_i        = s.rs;
    rs2_i        = s.rs;
  endtask

  task automatic report_mismatch(string nm, string what, logic [31:0] exp_v,
                                 logic [31:0] act_v);
    $display("** Error %s: %s expected %0h actual %0h", nm, what, exp_v, act_v);
    errors++;
  endtask

  task automatic check_row(string nm, exp_t e);
    logic [3:0] flags;
    flags = {issue_instr_valid_o, decoded_instr_ack_o, sb_full_o, commit_instr_o[0].valid};
    if (flags !== e.flags) report_mismatch(nm, "valid flags", e.flags, flags);
    // data fields only mean something under their valid
    if (e.flags[3] && issue_instr_o.trans_id !== e.tid)
      report_mismatch(nm, "issue trans_id", e.tid, issue_instr_o.trans_id);
    if (e.flags[0] && commit_instr_o[0].result !== e.cres)
      report_mismatch(nm, "commit result", e.cres, commit_instr_o[0].result);
    if (rd_clobber_o[e.clob_reg] !== e.clob)
      report_mismatch(nm, "clobber fu", e.clob, rd_clobber_o[e.clob_reg]);
    if (rs1_valid_o !== e.rsv) report_mismatch(nm, "rs1 valid", e.rsv, rs1_valid_o);
    if (e.rsv && rs1_o !== e.rs) report_mismatch(nm, "rs1 data", e.rs, rs1_o);
    if (rs2_valid_o !== e.rsv) report_mismatch(nm, "rs2 valid", e.rsv, rs2_valid_o);
    if (e.rsv && rs2_o !== e.rs) report_mismatch(nm, "rs2 data", e.rs, rs2_o);
  endtask

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // watchdog, sized from the table length
  initial begin : watchdog
    wait (n_rows > 0);
    #((n_rows + 20) * 100);
    $display("timeout: the step table did not complete in time");
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin : main
    sb_pkg::trans_id_t tid;
    sb_pkg::xlen_t     data;
    sb_pkg::reg_addr_t rs;
    logic [32:0]       fwd;
    int                seed;

    seed = 73;
    void'($urandom(seed));
    drive_inputs('0);
    rst_ni = 1'b0;

    // ------------------------------
    // directed steps
    // ------------------------------
    add_row("reset_idle", stim_t'{1'b0, sb_pkg::NONE, 5'd0, 4'b0000, no_wb, 2'b00, 5'd0},
            exp_t'{4'b0000, 3'd0, 32'h0, 5'd1, sb_pkg::NONE, 1'b0, 32'h0});
    add_row("issue_alu_x3", stim_t'{1'b1, sb_pkg::ALU, 5'd3, 4'b1000, no_wb, 2'b00, 5'd3},
            exp_t'{4'b1100, 3'd0, 32'h0, 5'd3, sb_pkg::NONE, 1'b0, 32'h0});
    add_row("issue_ld_x3", stim_t'{1'b1, sb_pkg::LOAD, 5'd3, 4'b1000, no_wb, 2'b00, 5'd3},
            exp_t'{4'b1100, 3'd1, 32'h0, 5'd3, sb_pkg::ALU, 1'b0, 32'h0});
    add_row("issue_none_x0", stim_t'{1'b1, sb_pkg::NONE, 5'd0, 4'b1000, no_wb, 2'b00, 5'd3},
            exp_t'{4'b1100, 3'd2, 32'h0, 5'd3, sb_pkg::ALU, 1'b0, 32'h0});
    // held branch blocks issue, x0 stays free and unforwarded
    add_row("branch_hold", stim_t'{1'b1, sb_pkg::MULT, 5'd5, 4'b0100, no_wb, 2'b00, 5'd0},
            exp_t'{4'b0000, 3'd0, 32'h0, 5'd0, sb_pkg::NONE, 1'b0, 32'h0});
    add_row("flush_unissued", stim_t'{1'b1, sb_pkg::MULT, 5'd5, 4'b1001, no_wb, 2'b00, 5'd0},
            exp_t'{4'b1100, 3'd3, 32'h0, 5'd5, sb_pkg::NONE, 1'b0, 32'h0});
    add_row("wb_same_cycle", stim_t'{1'b0, sb_pkg::NONE, 5'd0, 4'b0000,
                                     make_wb(3'd0, 32'h1111_0000), 2'b00, 5'd3},
            exp_t'{4'b0000, 3'd0, 32'h0, 5'd5, sb_pkg::NONE, 1'b1, 32'h1111_0000});
    add_row("commit_port0", stim_t'{1'b0, sb_pkg::NONE, 5'd0, 4'b0000, no_wb, 2'b00, 5'd3},
            exp_t'{4'b0001, 3'd0, 32'h1111_0000, 5'd3, sb_pkg::ALU, 1'b1, 32'h1111_0000});
    add_row("wb_beats_store", stim_t'{1'b0, sb_pkg::NONE, 5'd0, 4'b0000,
                                      make_wb(3'd1, 32'h2222_0000), 2'b00, 5'd3},
            exp_t'{4'b0001, 3'd0, 32'h1111_0000, 5'd3, sb_pkg::ALU, 1'b1, 32'h2222_0000});
    add_row("commit_both", stim_t'{1'b0, sb_pkg::NONE, 5'd0, 4'b0000, no_wb, 2'b11, 5'd3},
            exp_t'{4'b0001, 3'd0, 32'h1111_0000, 5'd3, sb_pkg::ALU, 1'b1, 32'h1111_0000});
    add_row("commit_none_fu", stim_t'{1'b0, sb_pkg::NONE, 5'd0, 4'b0000, no_wb, 2'b01, 5'd3},
            exp_t'{4'b0001, 3'd0, 32'h0, 5'd3, sb_pkg::NONE, 1'b0, 32'h0});
    // seven issues fill the store
    add_row("fill_t3_none", stim_t'{1'b1, sb_pkg::NONE, 5'd9, 4'b1000, no_wb, 2'b00, 5'd0},
            exp_t'{4'b1100, 3'd3, 32'h0, 5'd9, sb_pkg::NONE, 1'b0, 32'h0});
    add_row("fill_t4", stim_t'{1'b1, sb_pkg::ALU, 5'd7, 4'b1000, no_wb, 2'b00, 5'd0},
            exp_t'{4'b1100, 3'd4, 32'h0, 5'd7, sb_pkg::NONE, 1'b0, 32'h0});
    add_row("fill_t5", stim_t'{1'b1, sb_pkg::ALU, 5'd7, 4'b1000, no_wb, 2'b00, 5'd0},
            exp_t'{4'b1101, 3'd5, 32'h0, 5'd7, sb_pkg::ALU, 1'b0, 32'h0});
    add_row("fill_t6", stim_t'{1'b1, sb_pkg::MULT, 5'd7, 4'b1000, no_wb, 2'b00, 5'd0},
            exp_t'{4'b1101, 3'd6, 32'h0, 5'd7, sb_pkg::ALU, 1'b0, 32'h0});
    add_row("fill_t7", stim_t'{1'b1, sb_pkg::CSR, 5'd7, 4'b1000, no_wb, 2'b00, 5'd0},
            exp_t'{4'b1101, 3'd7, 32'h0, 5'd7, sb_pkg::ALU, 1'b0, 32'h0});
    add_row("fill_t0", stim_t'{1'b1, sb_pkg::STORE, 5'd12, 4'b1000, no_wb, 2'b00, 5'd0},
            exp_t'{4'b1101, 3'd0, 32'h0, 5'd7, sb_pkg::ALU, 1'b0, 32'h0});
    add_row("fill_t1", stim_t'{1'b1, sb_pkg::LOAD, 5'd12, 4'b1000, no_wb, 2'b00, 5'd0},
            exp_t'{4'b1101, 3'd1, 32'h0, 5'd12, sb_pkg::STORE, 1'b0, 32'h0});
    add_row("full_hold", stim_t'{1'b1, sb_pkg::ALU, 5'd4, 4'b0000, no_wb, 2'b00, 5'd0},
            exp_t'{4'b0011, 3'd0, 32'h0, 5'd12, sb_pkg::STORE, 1'b0, 32'h0});
    add_row("commit_frees", stim_t'{1'b0, sb_pkg::NONE, 5'd0, 4'b0000, no_wb, 2'b01, 5'd0},
            exp_t'{4'b0011, 3'd0, 32'h0, 5'd12, sb_pkg::STORE, 1'b0, 32'h0});
    add_row("full_cleared", stim_t'{1'b1, sb_pkg::ALU, 5'd4, 4'b0000, no_wb, 2'b00, 5'd0},
            exp_t'{4'b1000, 3'd2, 32'h0, 5'd12, sb_pkg::STORE, 1'b0, 32'h0});

    // ------------------------------
    // random write-backs to entries 4..7, 0, 1
    // ------------------------------
    mdl_valid = '0;
    for (int n = 0; n < 6; n++) begin
      tid  = sb_pkg::trans_id_t'(4 + $urandom_range(5, 0));
      data = $urandom;
      rs   = ($urandom_range(1, 0) == 1) ? 5'd7 : 5'd12;
      fwd  = fwd_ref(tid, data, rs);
      // commit port 0 sits on entry 4
      add_row($sformatf("rand_wb%0d", n),
              stim_t'{1'b0, sb_pkg::NONE, 5'd0, 4'b0000, make_wb(tid, data), 2'b00, rs},
              exp_t'{{3'b000, mdl_valid[4]}, 3'd0, mdl_res[4], 5'd7, sb_pkg::ALU,
                     fwd[32], fwd[31:0]});
      mdl_valid[tid] = 1'b1;
      mdl_res[tid]   = data;
    end
    add_row("flush_all", stim_t'{1'b0, sb_pkg::NONE, 5'd0, 4'b0010, no_wb, 2'b00, 5'd0},
            exp_t'{{3'b000, mdl_valid[4]}, 3'd0, mdl_res[4], 5'd7, sb_pkg::ALU, 1'b0, 32'h0});
    // first issue after flush targets x0, which must never show a writer
    add_row("after_flush", stim_t'{1'b1, sb_pkg::ALU, 5'd0, 4'b1000, no_wb, 2'b00, 5'd7},
            exp_t'{4'b1100, 3'd0, 32'h0, 5'd7, sb_pkg::NONE, 1'b0, 32'h0});
    add_row("x0_write_free", stim_t'{1'b0, sb_pkg::NONE, 5'd0, 4'b0000, no_wb, 2'b00, 5'd0},
            exp_t'{4'b0000, 3'd0, 32'h0, 5'd0, sb_pkg::NONE, 1'b0, 32'h0});
    n_rows = names.size();

    repeat (5) @(posedge clk_i);
    #1 rst_ni = 1'b1;

    // drive just after the edge, check well before the next one
    for (int r = 0; r < n_rows; r++) begin
      @(posedge clk_i);
      #1;
      drive_inputs(stims[r]);
      #58;
      check_row(names[r], exps[r]);
    end

    $display("tb_scoreboard: %0d steps, %0d errors", n_rows, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: tb.f
+incdir+src
src/sb_pkg.sv
src/sb_prio_select.sv
src/sb_entry_store.sv
src/sb_clobber.sv
src/sb_operand_fwd.sv
src/scoreboard_top.sv
dv/tb_scoreboard.sv

// File: Bender.yml
package:
  name: scoreboard

export_include_dirs:
  - src

sources:
  - files:
      - src/sb_pkg.sv
      - src/sb_prio_select.sv
      - src/sb_entry_store.sv
      - src/sb_clobber.sv
      - src/sb_operand_fwd.sv
      - src/scoreboard_top.sv
  - target: test
    files:
      - dv/tb_scoreboard.sv
